//--- sources.f
design/pic_pkg.sv
design/pic_regs.sv
design/pic_init_seq.sv
design/pic_request.sv
design/pic_service.sv
design/pic_top.sv
test/pic_chk.sv
test/pic_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -f sources.f --top-module pic_tb -o pic_sim &&
./obj_dir/pic_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- test/pic_tb.sv
// PIC testbench
// Table of directed operations with hand-worked expected values, then
// LFSR rounds in fixed priority checked against a small winner model

`timescale 1ns/100ps

module pic_tb;

    // ==================================================================
    // Table layout
    // ==================================================================
    localparam logic [2:0] OP_WR   = 3'd0;   // Write a0, data
    localparam logic [2:0] OP_IRQ  = 3'd1;   // data goes to irq pins
    localparam logic [2:0] OP_ACK  = 3'd2;   // One inta pulse
    localparam logic [2:0] OP_IDLE = 3'd3;
    localparam logic [2:0] OP_RD   = 3'd4;   // Read at a0, compare byte

    localparam int NUM_ROWS = 69;
    localparam int NUM_RAND = 16;
    localparam int TIMEOUT  = (NUM_ROWS + NUM_RAND * 20 + 20) * 10;

    typedef struct packed {
        logic [2:0]           op;
        logic                 a0;
        logic [7:0]           data;
        logic                 exp_int;
        pic_pkg::pic_vector_t exp_vec;
        pic_pkg::pic_irq_t    exp_rd;
    } row_t;

    logic                 clk;
    logic                 rst;
    logic                 wr;
    logic                 a0;
    logic [7:0]           wdata;
    logic [7:0]           rd_data;
    pic_pkg::pic_irq_t    irq;
    logic                 int_req;
    logic                 inta;
    pic_pkg::pic_vector_t vector;

    row_t                 rows [NUM_ROWS];
    logic [31:0]          lfsr;

    pic_top dut_i (
        .clk, .rst, .wr, .a0, .wdata, .rd_data, .irq, .int_req, .inta, .vector
    );

    always #5 clk = ~clk;

    // ==================================================================
    // Helpers
    // ==================================================================
    function automatic row_t mk(input logic [2:0] op, input logic a, input logic [7:0] d,
                                input logic i, input logic [7:0] v, input logic [7:0] r);
        return '{op: op, a0: a, data: d, exp_int: i, exp_vec: v, exp_rd: r};
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_byte(output logic [7:0] r);
        r = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[6:0], lfsr[0]};
        end
    endtask

    // Reference fixed priority, IRQ0 on top
    function automatic pic_pkg::pic_level_t lowest_set(input pic_pkg::pic_irq_t b);
        pic_pkg::pic_level_t l;
        l = '0;
        for (int i = pic_pkg::NUM_IRQ - 1; i >= 0; i--) begin
            if (b[i]) l = 3'(i);
        end
        return l;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_irq(input string name, input pic_pkg::pic_irq_t got,
                             input pic_pkg::pic_irq_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_vector(input pic_pkg::pic_vector_t got, input pic_pkg::pic_vector_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: vector got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic check_int(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: int_req got %b expected %b", $time, got, exp));
        end
    endtask

    // Called at a falling edge, returns at the next one with strobes low
    task automatic drive_cycle(input logic w, input logic a, input logic [7:0] d, input logic k);
        wr    = w;
        a0    = a;
        wdata = d;
        inta  = k;
        @(posedge clk);
        @(negedge clk);
        wr   = 1'b0;
        inta = 1'b0;
    endtask

    // ==================================================================
    // Directed table
    // ==================================================================
    task automatic fill_rows();
        // Reset state, single mode with ICW4, IRQ0 held before ready
        rows[0]  = mk(OP_RD,   1, 8'h00, 0, 8'h00, 8'hFF);
        rows[1]  = mk(OP_IRQ,  0, 8'h01, 0, 8'h00, 8'h00);
        rows[2]  = mk(OP_WR,   0, 8'h13, 0, 8'h00, 8'h00);  // ICW1 edge, sngl, ic4
        rows[3]  = mk(OP_WR,   1, 8'h40, 0, 8'h00, 8'h00);  // Base 8
        rows[4]  = mk(OP_WR,   1, 8'h01, 0, 8'h00, 8'h00);  // ICW4, no aeoi
        rows[5]  = mk(OP_IDLE, 0, 8'h00, 0, 8'h00, 8'h00);
        rows[6]  = mk(OP_RD,   0, 8'h00, 0, 8'h00, 8'h00);  // Held line, no edge
        rows[7]  = mk(OP_IRQ,  0, 8'h00, 0, 8'h00, 8'h00);
        rows[8]  = mk(OP_IRQ,  0, 8'h01, 1, 8'h00, 8'h00);
        rows[9]  = mk(OP_RD,   0, 8'h00, 1, 8'h00, 8'h01);
        rows[10] = mk(OP_ACK,  0, 8'h00, 0, 8'h40, 8'h00);
        rows[11] = mk(OP_RD,   0, 8'h00, 0, 8'h40, 8'h00);  // Still high, one request
        rows[12] = mk(OP_WR,   0, 8'h0B, 0, 8'h40, 8'h00);  // OCW3 read ISR
        rows[13] = mk(OP_RD,   0, 8'h00, 0, 8'h40, 8'h01);
        rows[14] = mk(OP_WR,   0, 8'h20, 0, 8'h40, 8'h00);  // Non-specific EOI
        rows[15] = mk(OP_RD,   0, 8'h00, 0, 8'h40, 8'h00);
        // Fixed order, ISR blocks lower
        rows[16] = mk(OP_IRQ,  0, 8'h00, 0, 8'h40, 8'h00);
        rows[17] = mk(OP_IRQ,  0, 8'h0C, 1, 8'h40, 8'h00);
        rows[18] = mk(OP_ACK,  0, 8'h00, 0, 8'h42, 8'h00);
        rows[19] = mk(OP_WR,   0, 8'h20, 1, 8'h42, 8'h00);
        rows[20] = mk(OP_ACK,  0, 8'h00, 0, 8'h43, 8'h00);
        rows[21] = mk(OP_WR,   0, 8'h20, 0, 8'h43, 8'h00);
        // Mask IRQ1, then higher level nests over IRQ2
        rows[22] = mk(OP_WR,   1, 8'h02, 0, 8'h43, 8'h00);
        rows[23] = mk(OP_IRQ,  0, 8'h00, 0, 8'h43, 8'h00);
        rows[24] = mk(OP_IRQ,  0, 8'h06, 1, 8'h43, 8'h00);
        rows[25] = mk(OP_ACK,  0, 8'h00, 0, 8'h42, 8'h00);
        rows[26] = mk(OP_WR,   1, 8'h00, 1, 8'h42, 8'h00);
        rows[27] = mk(OP_ACK,  0, 8'h00, 0, 8'h41, 8'h00);
        rows[28] = mk(OP_WR,   0, 8'h61, 0, 8'h41, 8'h00);  // Specific EOI 1
        rows[29] = mk(OP_RD,   0, 8'h00, 0, 8'h41, 8'h04);
        rows[30] = mk(OP_WR,   0, 8'h20, 0, 8'h41, 8'h00);
        // Rotation, IRQ2 lowest then rotate on EOI
        rows[31] = mk(OP_WR,   0, 8'hC2, 0, 8'h41, 8'h00);
        rows[32] = mk(OP_IRQ,  0, 8'h00, 0, 8'h41, 8'h00);
        rows[33] = mk(OP_IRQ,  0, 8'h05, 1, 8'h41, 8'h00);
        rows[34] = mk(OP_ACK,  0, 8'h00, 0, 8'h40, 8'h00);
        rows[35] = mk(OP_WR,   0, 8'hA0, 1, 8'h40, 8'h00);
        rows[36] = mk(OP_ACK,  0, 8'h00, 0, 8'h42, 8'h00);
        rows[37] = mk(OP_WR,   0, 8'hA0, 0, 8'h42, 8'h00);
        rows[38] = mk(OP_WR,   0, 8'hC7, 0, 8'h42, 8'h00);  // Back to IRQ0 on top
        // Special mask mode
        rows[39] = mk(OP_IRQ,  0, 8'h00, 0, 8'h42, 8'h00);
        rows[40] = mk(OP_IRQ,  0, 8'h04, 1, 8'h42, 8'h00);
        rows[41] = mk(OP_ACK,  0, 8'h00, 0, 8'h42, 8'h00);
        rows[42] = mk(OP_WR,   0, 8'h68, 0, 8'h42, 8'h00);
        rows[43] = mk(OP_IRQ,  0, 8'h24, 1, 8'h42, 8'h00);  // IRQ5 under IRQ2
        rows[44] = mk(OP_ACK,  0, 8'h00, 0, 8'h45, 8'h00);
        rows[45] = mk(OP_WR,   0, 8'h65, 0, 8'h45, 8'h00);
        rows[46] = mk(OP_WR,   0, 8'h62, 0, 8'h45, 8'h00);
        rows[47] = mk(OP_WR,   0, 8'h48, 0, 8'h45, 8'h00);
        rows[48] = mk(OP_RD,   0, 8'h00, 0, 8'h45, 8'h00);
        // Level mode with auto EOI, base 16
        rows[49] = mk(OP_IRQ,  0, 8'h00, 0, 8'h45, 8'h00);
        rows[50] = mk(OP_WR,   0, 8'h1B, 0, 8'h45, 8'h00);
        rows[51] = mk(OP_WR,   1, 8'h80, 0, 8'h45, 8'h00);
        rows[52] = mk(OP_WR,   1, 8'h02, 0, 8'h45, 8'h00);
        rows[53] = mk(OP_IRQ,  0, 8'h10, 1, 8'h45, 8'h00);
        rows[54] = mk(OP_ACK,  0, 8'h00, 1, 8'h84, 8'h00);  // Re-latched same edge
        rows[55] = mk(OP_RD,   0, 8'h00, 1, 8'h84, 8'h10);
        rows[56] = mk(OP_WR,   0, 8'h0B, 1, 8'h84, 8'h00);
        rows[57] = mk(OP_RD,   0, 8'h00, 1, 8'h84, 8'h00);  // ISR empty
        rows[58] = mk(OP_IRQ,  0, 8'h00, 1, 8'h84, 8'h00);
        rows[59] = mk(OP_ACK,  0, 8'h00, 0, 8'h84, 8'h00);
        // Rotate on auto EOI
        rows[60] = mk(OP_WR,   0, 8'h80, 0, 8'h84, 8'h00);
        rows[61] = mk(OP_IRQ,  0, 8'h03, 1, 8'h84, 8'h00);
        rows[62] = mk(OP_ACK,  0, 8'h00, 1, 8'h80, 8'h00);
        rows[63] = mk(OP_ACK,  0, 8'h00, 1, 8'h81, 8'h00);
        rows[64] = mk(OP_ACK,  0, 8'h00, 1, 8'h80, 8'h00);
        // Re-init edge mode without ICW4, base 8, for the random rounds
        rows[65] = mk(OP_IRQ,  0, 8'h00, 1, 8'h80, 8'h00);
        rows[66] = mk(OP_WR,   0, 8'h12, 0, 8'h80, 8'h00);  // ICW1 edge, sngl, no ICW4
        rows[67] = mk(OP_WR,   1, 8'h40, 0, 8'h80, 8'h00);  // Base 8, ready next
        rows[68] = mk(OP_RD,   1, 8'h00, 0, 8'h80, 8'h00);  // IMR cleared by ICW1
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        pic_pkg::pic_irq_t    mask;
        pic_pkg::pic_irq_t    pattern;
        pic_pkg::pic_irq_t    model_irr;
        pic_pkg::pic_level_t  lvl;
        pic_pkg::pic_vector_t model_vec;
        clk   = 1'b0;
        rst   = 1'b1;
        wr    = 1'b0;
        a0    = 1'b0;
        wdata = '0;
        irq   = '0;
        inta  = 1'b0;
        lfsr  = 32'h3fae99b1;
        fill_rows();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (rows[n]) begin
            if (rows[n].op == OP_IRQ) irq = rows[n].data;
            drive_cycle(rows[n].op == OP_WR, rows[n].a0, rows[n].data, rows[n].op == OP_ACK);
            check_int(int_req, rows[n].exp_int);
            check_vector(vector, rows[n].exp_vec);
            if (rows[n].op == OP_RD) check_irq("rd_data", rd_data, rows[n].exp_rd);
        end

        // Random rounds, edge mode, fixed priority
        model_irr = '0;
        for (int r = 0; r < NUM_RAND; r++) begin
            rand_byte(mask);
            rand_byte(pattern);
            drive_cycle(1'b1, 1'b1, mask, 1'b0);        // OCW1
            irq = '0;
            drive_cycle(1'b0, 1'b0, 8'h00, 1'b0);
            irq = pattern;
            drive_cycle(1'b0, 1'b0, 8'h00, 1'b0);
            model_irr = model_irr | pattern;            // Masked bits stay pending
            check_irq("rd_data", rd_data, model_irr);
            while ((model_irr & ~mask) != '0) begin
                lvl = lowest_set(model_irr & ~mask);
                check_int(int_req, 1'b1);
                drive_cycle(1'b0, 1'b0, 8'h00, 1'b1);
                model_vec = {5'd8, lvl};
                check_vector(vector, model_vec);
                drive_cycle(1'b1, 1'b0, 8'h20, 1'b0);   // Non-specific EOI
                model_irr[lvl] = 1'b0;
            end
            check_int(int_req, 1'b0);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        fail_run("Timeout: the test sequence did not finish in time");
    end

endmodule

//--- test/pic_chk.sv
// PIC protocol checks
// Bound into pic_top, watches INT, vector latch and ack strobes

`timescale 1ns/100ps

module pic_chk (
    input logic                 clk,
    input logic                 rst,
    input pic_pkg::pic_step_t   step,
    input logic                 inta,
    input logic                 int_req,
    input pic_pkg::pic_vector_t vector,
    input pic_pkg::pic_irq_t    ack_onehot,
    input pic_pkg::pic_irq_t    isr
);

    // No interrupt before init completes, nor before IRR could latch
    int_ready_a: assert property (@(posedge clk) disable iff (rst)
        int_req |-> step == pic_pkg::READY && $past(step) == pic_pkg::READY)
        else $error("int_req high outside READY");

    // Vector moves only after an accepted acknowledge
    vector_a: assert property (@(posedge clk) disable iff (rst)
        !$stable(vector) |-> $past(inta && int_req))
        else $error("vector changed without an accepted inta");

    // Acknowledged level never already in service
    ack_a: assert property (@(posedge clk) disable iff (rst)
        (ack_onehot & isr) == '0)
        else $error("ack_onehot hits a level already in service");

endmodule

bind pic_top pic_chk chk_i (
    .clk(clk), .rst(rst), .step(step), .inta(inta), .int_req(int_req),
    .vector(vector), .ack_onehot(ack_onehot), .isr(isr)
);

//--- design/pic_top.sv
// 8259-style programmable interrupt controller, single chip
// Register interface, init sequencer, request stage and service stage

`timescale 1ns/100ps

module pic_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr,
    input  logic                 a0,
    input  logic [7:0]           wdata,
    output logic [7:0]           rd_data,
    input  pic_pkg::pic_irq_t    irq,
    output logic                 int_req,
    input  logic                 inta,
    output pic_pkg::pic_vector_t vector
);

    pic_pkg::pic_step_t step;
    logic               ready;
    logic               icw1_wr;
    logic               data_wr;
    pic_pkg::pic_cfg_t  cfg;
    pic_pkg::pic_irq_t  imr;
    pic_pkg::pic_irq_t  irr;
    pic_pkg::pic_irq_t  isr;
    pic_pkg::pic_irq_t  ack_onehot;
    pic_pkg::pic_eoi_t  eoi;
    pic_pkg::pic_smm_t  smm;

    // ==================================================================
    // Blocks
    // ==================================================================
    pic_regs regs_i (
        .clk, .rst, .wr, .a0, .wdata, .rd_data,
        .step, .irr, .isr,
        .icw1_wr, .data_wr, .cfg, .imr, .eoi, .smm
    );

    pic_init_seq init_i (
        .clk, .rst, .icw1_wr, .data_wr, .cfg, .step, .ready
    );

    pic_request req_i (
        .clk, .rst, .irq, .cfg, .ready, .ack_onehot, .irr
    );

    pic_service svc_i (
        .clk, .rst, .irr, .imr, .cfg, .ready, .icw1_wr, .eoi, .smm,
        .inta, .isr, .int_req, .vector, .ack_onehot
    );

endmodule

//--- design/pic_service.sv
// PIC service stage
// Priority resolution over IRR and ISR, EOI and rotation commands,
// special mask mode, INT output and the INTA vector latch

`timescale 1ns/100ps

module pic_service (
    input  logic                 clk,
    input  logic                 rst,
    input  pic_pkg::pic_irq_t    irr,
    input  pic_pkg::pic_irq_t    imr,
    input  pic_pkg::pic_cfg_t    cfg,
    input  logic                 ready,
    input  logic                 icw1_wr,
    input  pic_pkg::pic_eoi_t    eoi,
    input  pic_pkg::pic_smm_t    smm,
    input  logic                 inta,
    output pic_pkg::pic_irq_t    isr,
    output logic                 int_req,
    output pic_pkg::pic_vector_t vector,
    output pic_pkg::pic_irq_t    ack_onehot
);

    pic_pkg::pic_level_t rot_base;   // Lowest priority level
    logic                rot_aeoi;   // Rotate on auto EOI
    logic                smm_on;     // Special mask mode
    pic_pkg::pic_irq_t   req;        // Unmasked pending
    pic_pkg::pic_irq_t   cand;
    pic_pkg::pic_irq_t   isr_set;
    pic_pkg::pic_irq_t   isr_clr;
    logic                win_hit;
    logic                isr_hit;
    pic_pkg::pic_level_t win_lvl;
    pic_pkg::pic_level_t isr_lvl;
    logic                ack;
    logic                eoi_go;

    // First set bit walking up from base+1, returns {hit, level}
    function automatic logic [3:0] pick(input pic_pkg::pic_irq_t bits,
                                        input pic_pkg::pic_level_t base);
        pic_pkg::pic_level_t idx;
        pic_pkg::pic_level_t lvl;
        logic                hit;
        hit = 1'b0;
        lvl = '0;
        for (int i = 0; i < pic_pkg::NUM_IRQ; i++) begin
            idx = base + 3'(i) + 3'd1;
            if (!hit && bits[idx]) begin
                hit = 1'b1;
                lvl = idx;
            end
        end
        return {hit, lvl};
    endfunction

    // Distance from the top of the ring, 0 is highest
    function automatic pic_pkg::pic_level_t rank(input pic_pkg::pic_level_t lvl,
                                                 input pic_pkg::pic_level_t base);
        return lvl - base - 3'd1;
    endfunction

    // ==================================================================
    // Priority resolution
    // ==================================================================
    assign req = irr & ~imr;

    // In special mask mode only the serviced level itself is held off
    assign cand = smm_on ? (req & ~isr) : req;

    assign {win_hit, win_lvl} = pick(cand, rot_base);
    assign {isr_hit, isr_lvl} = pick(isr, rot_base);

    assign int_req = ready && win_hit &&
                     (smm_on || !isr_hit ||
                      (rank(win_lvl, rot_base) < rank(isr_lvl, rot_base)));

    assign ack    = inta && int_req;     // inta alone is ignored
    assign eoi_go = eoi.valid && ready;

    always_comb begin
        ack_onehot = '0;
        if (ack) begin
            ack_onehot[win_lvl] = 1'b1;
        end
    end

    // ==================================================================
    // ISR set and clear
    // ==================================================================
    assign isr_set = cfg.aeoi ? '0 : ack_onehot;

    always_comb begin
        isr_clr = '0;
        if (eoi_go) begin
            case (eoi.code)
                pic_pkg::EOI_NONSPEC,
                pic_pkg::EOI_ROT_NONSPEC: if (isr_hit) isr_clr[isr_lvl] = 1'b1;
                pic_pkg::EOI_SPEC,
                pic_pkg::EOI_ROT_SPEC:    isr_clr[eoi.level] = 1'b1;
                default: ;
            endcase
        end
    end

    // ==================================================================
    // Control state
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst || icw1_wr) begin
            isr      <= '0;
            rot_base <= 3'd7;              // IRQ0 on top
            rot_aeoi <= 1'b0;
            smm_on   <= 1'b0;
        end else begin
            isr <= (isr & ~isr_clr) | isr_set;
            if (smm.valid && ready) begin
                smm_on <= smm.set;
            end
            if (eoi_go) begin
                case (eoi.code)
                    pic_pkg::ROT_AEOI_SET:    rot_aeoi <= 1'b1;
                    pic_pkg::ROT_AEOI_CLR:    rot_aeoi <= 1'b0;
                    pic_pkg::EOI_ROT_NONSPEC: if (isr_hit) rot_base <= isr_lvl;
                    pic_pkg::EOI_ROT_SPEC,
                    pic_pkg::SET_PRIORITY:    rot_base <= eoi.level;
                    default: ;
                endcase
            end else if (ack && cfg.aeoi && rot_aeoi) begin
                rot_base <= win_lvl;       // Serviced level drops to bottom
            end
        end
    end

    // Vector held until the next accepted ack
    always_ff @(posedge clk) begin
        if (rst) begin
            vector <= '0;
        end else if (ack) begin
            vector <= {cfg.base, win_lvl};
        end
    end

endmodule

//--- design/pic_request.sv
// PIC request stage
// Edge or level detection on IRQ0-7 and the Interrupt Request Register

`timescale 1ns/100ps

module pic_request (
    input  logic               clk,
    input  logic               rst,
    input  pic_pkg::pic_irq_t  irq,
    input  pic_pkg::pic_cfg_t  cfg,
    input  logic               ready,
    input  pic_pkg::pic_irq_t  ack_onehot,  // Bit taken by INTA
    output pic_pkg::pic_irq_t  irr
);

    pic_pkg::pic_irq_t irq_q;      // Last sample
    pic_pkg::pic_irq_t trig;

    // ==================================================================
    // Trigger detect
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_q <= '0;
        end else begin
            irq_q <= irq;
        end
    end

    // Level mode latches every cycle the line is high
    assign trig = cfg.ltim ? irq : (irq & ~irq_q);

    // ==================================================================
    // IRR
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            irr <= '0;
        end else if (!ready) begin
            irr <= '0;                          // Nothing latched before init
        end else begin
            // A held level line sets its bit again right after the ack
            irr <= (irr & ~ack_onehot) | trig;
        end
    end

endmodule

//--- design/pic_init_seq.sv
// PIC initialization sequencer
// Steps through ICW2, ICW3 and ICW4 after an ICW1 and flags READY

`timescale 1ns/100ps

module pic_init_seq (
    input  logic                clk,
    input  logic                rst,
    input  logic                icw1_wr,
    input  logic                data_wr,
    input  pic_pkg::pic_cfg_t   cfg,
    output pic_pkg::pic_step_t  step,
    output logic                ready
);

    pic_pkg::pic_step_t step_nxt;

    // ==================================================================
    // Next step
    // ==================================================================
    always_comb begin
        step_nxt = step;
        if (icw1_wr) begin
            step_nxt = pic_pkg::WAIT_ICW2;      // Restarts from any step
        end else if (data_wr) begin
            case (step)
                pic_pkg::WAIT_ICW2: begin
                    if (!cfg.sngl) begin
                        step_nxt = pic_pkg::WAIT_ICW3;
                    end else if (cfg.ic4) begin
                        step_nxt = pic_pkg::WAIT_ICW4;
                    end else begin
                        step_nxt = pic_pkg::READY;
                    end
                end
                pic_pkg::WAIT_ICW3: begin
                    step_nxt = cfg.ic4 ? pic_pkg::WAIT_ICW4 : pic_pkg::READY;
                end
                pic_pkg::WAIT_ICW4: step_nxt = pic_pkg::READY;
                default: ;                      // IDLE and READY hold
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= pic_pkg::IDLE;
        end else begin
            step <= step_nxt;
        end
    end

    assign ready = (step == pic_pkg::READY);

endmodule

//--- design/pic_regs.sv
// PIC CPU register interface
// Decodes address-0 command bytes and address-1 data bytes, holds the
// ICW configuration, IMR and read select, and muxes read data

`timescale 1ns/100ps

module pic_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr,       // One-cycle write strobe
    input  logic                a0,
    input  logic [7:0]          wdata,
    output logic [7:0]          rd_data,
    input  pic_pkg::pic_step_t  step,
    input  pic_pkg::pic_irq_t   irr,
    input  pic_pkg::pic_irq_t   isr,
    output logic                icw1_wr,
    output logic                data_wr,
    output pic_pkg::pic_cfg_t   cfg,
    output pic_pkg::pic_irq_t   imr,
    output pic_pkg::pic_eoi_t   eoi,
    output pic_pkg::pic_smm_t   smm
);

    pic_pkg::pic_cmd_u cmd;       // Same byte, three layouts
    logic              cmd_wr;    // Address-0 write
    logic              ocw2_wr;
    logic              ocw3_wr;
    logic [1:0]        rd_sel;    // IRR or ISR on address-0 reads

    // ==================================================================
    // Write decode
    // ==================================================================
    assign cmd     = wdata;
    assign cmd_wr  = wr && !a0;
    assign data_wr = wr && a0;

    // Bit 4 marks ICW1, otherwise bit 3 splits OCW3 from OCW2
    assign icw1_wr = cmd_wr && cmd.icw1.sel;
    assign ocw2_wr = cmd_wr && (cmd.ocw2.sel == 2'b00);
    assign ocw3_wr = cmd_wr && (cmd.ocw3.sel == 2'b01);

    // Commands go straight to the service stage
    assign eoi = '{valid: ocw2_wr, code: cmd.ocw2.code, level: cmd.ocw2.level};
    assign smm = '{valid: ocw3_wr && cmd.ocw3.smm[1], set: cmd.ocw3.smm[0]};

    // ==================================================================
    // Programmable state
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg    <= '0;
            imr    <= '1;               // Everything masked out of reset
            rd_sel <= pic_pkg::RD_IRR;
        end else if (icw1_wr) begin
            // New init sequence
            cfg.ltim <= cmd.icw1.ltim;
            cfg.sngl <= cmd.icw1.sngl;
            cfg.ic4  <= cmd.icw1.ic4;
            cfg.aeoi <= 1'b0;           // Set again only by ICW4
            imr      <= '0;
            rd_sel   <= pic_pkg::RD_IRR;
        end else if (data_wr) begin
            // Address-1 byte goes where the sequencer points
            case (step)
                pic_pkg::WAIT_ICW2: cfg.base    <= wdata[7:3];
                pic_pkg::WAIT_ICW3: cfg.cascade <= wdata;
                pic_pkg::WAIT_ICW4: cfg.aeoi    <= wdata[1];
                pic_pkg::READY:     imr         <= wdata;   // OCW1
                default: ;                                  // Dropped in IDLE
            endcase
        end else if (ocw3_wr && cmd.ocw3.rd_sel[1]) begin
            rd_sel <= cmd.ocw3.rd_sel;  // RR set, take RIS
        end
    end

    // ==================================================================
    // Read mux
    // ==================================================================
    always_comb begin
        if (a0) begin
            rd_data = imr;
        end else if (rd_sel == pic_pkg::RD_ISR) begin
            rd_data = isr;
        end else begin
            rd_data = irr;
        end
    end

endmodule

//--- design/pic_pkg.sv
// 8259-style interrupt controller shared definitions
// Widths, init steps, OCW2/OCW3 codes, configuration and command layouts

package pic_pkg;

    // ==================================================================
    // Sizes and basic types
    // ==================================================================
    localparam int NUM_IRQ = 8;           // One 8259, eight lines

    typedef logic [NUM_IRQ-1:0] pic_irq_t;    // IRR, ISR, IMR, irq pins
    typedef logic [2:0]         pic_level_t;  // IRQ number
    typedef logic [7:0]         pic_vector_t; // {base[4:0], level[2:0]}

    // Init sequence position
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        WAIT_ICW2 = 3'd1,
        WAIT_ICW3 = 3'd2,
        WAIT_ICW4 = 3'd3,
        READY     = 3'd4
    } pic_step_t;

    // ==================================================================
    // OCW2 and OCW3 codes
    // ==================================================================
    localparam logic [2:0] ROT_AEOI_CLR    = 3'b000;
    localparam logic [2:0] EOI_NONSPEC     = 3'b001;
    localparam logic [2:0] EOI_SPEC        = 3'b011;
    localparam logic [2:0] ROT_AEOI_SET    = 3'b100;
    localparam logic [2:0] EOI_ROT_NONSPEC = 3'b101;
    localparam logic [2:0] SET_PRIORITY    = 3'b110;
    localparam logic [2:0] EOI_ROT_SPEC    = 3'b111;

    localparam logic [1:0] RD_IRR = 2'b10;    // RR=1, RIS=0
    localparam logic [1:0] RD_ISR = 2'b11;    // RR=1, RIS=1

    // ==================================================================
    // Configuration and commands
    // ==================================================================
    typedef struct packed {
        logic       ltim;     // Level triggered
        logic       sngl;     // Single, no ICW3
        logic       ic4;      // ICW4 follows
        logic       aeoi;     // Auto EOI
        logic [4:0] base;     // Vector base, upper bits
        logic [7:0] cascade;  // ICW3 byte, stored only
    } pic_cfg_t;

    // Address-0 byte, three views
    typedef struct packed {
        logic [2:0] rsvd;     // A7-A5, not used here
        logic       sel;      // Set for ICW1
        logic       ltim;
        logic       adi;
        logic       sngl;
        logic       ic4;
    } pic_icw1_t;

    typedef struct packed {
        logic [2:0] code;     // R, SL, EOI
        logic [1:0] sel;      // 2'b00 for OCW2
        pic_level_t level;
    } pic_ocw2_t;

    typedef struct packed {
        logic       rsvd;
        logic [1:0] smm;      // ESMM, SMM
        logic [1:0] sel;      // 2'b01 for OCW3
        logic       poll;
        logic [1:0] rd_sel;   // RR, RIS
    } pic_ocw3_t;

    typedef union packed {
        pic_icw1_t icw1;
        pic_ocw2_t ocw2;
        pic_ocw3_t ocw3;
    } pic_cmd_u;

    // OCW2 handed to the service stage
    typedef struct packed {
        logic       valid;
        logic [2:0] code;
        pic_level_t level;
    } pic_eoi_t;

    // Special mask set/clear strobe
    typedef struct packed {
        logic valid;
        logic set;
    } pic_smm_t;

endpackage
